// File: common/nrvAlu_defines.svh
`ifndef NRVALU_DEFINES_SVH
`define NRVALU_DEFINES_SVH

// Datapath and bus geometry
`define ALU_WIDTH       32   // Operand and result width
`define SHAMT_WIDTH     5    // Shift amount field of in2
`define WB_ADR_WIDTH    3    // Word address bits on the slave port

// Default core options
`define ALU_TWOSTAGE    0    // 1 adds the four-bit shifter step
`define ALU_LATCH       0    // 1 registers non-shift results on wr

// Operation word layout
`define OP_FUNC_LSB     0    // Function code, low bit
`define OP_FUNC_MSB     2    // Function code, high bit
`define OP_QUAL_BIT     3    // Subtract for add, arithmetic for srl

// Status word layout
`define STATUS_BUSY_BIT 0    // Shifter still running

`endif

// File: common/nrvAluPkg.sv
package nrvAluPkg;

  // RV32I funct3 codes of the register-register ALU group
  typedef enum logic [2:0] {
    add   = 3'd0,  // ADD, or SUB with qualifier
    sll   = 3'd1,  // Shift left logical
    slt   = 3'd2,  // Signed less-than
    sltu  = 3'd3,  // Unsigned less-than
    xorOp = 3'd4,  // Bitwise XOR
    srl   = 3'd5,  // SRL, or SRA with qualifier
    orOp  = 3'd6,  // Bitwise OR
    andOp = 3'd7   // Bitwise AND
  } aluFunc;

  // Word addresses seen on the Wishbone port
  typedef enum logic [2:0] {
    in1Reg    = 3'd0,  // First operand
    in2Reg    = 3'd1,  // Second operand, shift amount in low bits
    opReg     = 3'd2,  // Operation word, write starts the op
    resultReg = 3'd3,  // ALU result
    sumReg    = 3'd4,  // Raw adder output
    statusReg = 3'd5   // Busy flag
  } regIndex;

endpackage

// File: alu/aluShifter.sv
`include "nrvAlu_defines.svh"

module aluShifter #(
  parameter bit TWOSTAGE = `ALU_TWOSTAGE  // Allow steps of four
) (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      wr,        // Start pulse from the slave
  input  nrvAluPkg::aluFunc         func,
  input  logic                      arith,     // Sign fill on right shifts
  input  logic [`ALU_WIDTH-1:0]     in1,       // Value to shift
  input  logic [`SHAMT_WIDTH-1:0]   shamtIn,   // Shift amount
  output logic [`ALU_WIDTH-1:0]     shiftReg,  // Working and final value
  output logic                      busy
);

  localparam int W = `ALU_WIDTH;

  logic [`SHAMT_WIDTH-1:0] shamt;     // Remaining count
  logic                    shiftLeft; // Direction held for the whole op
  logic                    shiftArith;
  logic                    isShift;
  logic                    bigStep;   // Four-bit step this cycle
  logic                    fill;

  assign isShift = (func == nrvAluPkg::sll) || (func == nrvAluPkg::srl);
  assign busy    = (shamt != '0);
  assign bigStep = TWOSTAGE && (shamt > `SHAMT_WIDTH'd4);
  assign fill    = shiftArith & shiftReg[W-1];  // Sign bit for SRA, else zero

  // Count and direction
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      shamt      <= '0;
      shiftLeft  <= 1'b0;
      shiftArith <= 1'b0;
    end else if (wr && isShift) begin
      shamt      <= shamtIn;
      shiftLeft  <= (func == nrvAluPkg::sll);
      shiftArith <= arith;
    end else if (bigStep) begin
      shamt <= shamt - `SHAMT_WIDTH'd4;
    end else if (busy) begin
      shamt <= shamt - `SHAMT_WIDTH'd1;
    end
  end

  // Data path, one or four positions per cycle
  always_ff @(posedge clk) begin
    if (wr && isShift) begin
      shiftReg <= in1;                                // Load operand
    end else if (bigStep) begin
      if (shiftLeft) begin
        shiftReg <= {shiftReg[W-5:0], 4'b0000};
      end else begin
        shiftReg <= {{4{fill}}, shiftReg[W-1:4]};
      end
    end else if (busy) begin
      if (shiftLeft) begin
        shiftReg <= {shiftReg[W-2:0], 1'b0};
      end else begin
        shiftReg <= {fill, shiftReg[W-1:1]};
      end
    end
  end

endmodule

// File: alu/aluCore.sv
`include "nrvAlu_defines.svh"

module aluCore #(
  parameter bit TWOSTAGE = `ALU_TWOSTAGE,  // Passed on to the shifter
  parameter bit LATCH    = `ALU_LATCH      // Register non-shift results
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [`ALU_WIDTH-1:0] in1,
  input  logic [`ALU_WIDTH-1:0] in2,
  input  nrvAluPkg::aluFunc     func,
  input  logic                  funcQual,  // Subtract or arithmetic
  input  logic                  wr,        // Operation start
  output logic [`ALU_WIDTH-1:0] result,
  output logic [`ALU_WIDTH-1:0] sum,       // Adder tap for address math
  output logic                  busy
);

  localparam int W = `ALU_WIDTH;

  logic [W:0]   minus;     // in1 - in2 with borrow out on top
  logic         lt;        // Signed in1 < in2
  logic         ltu;       // Unsigned in1 < in2
  logic [W-1:0] shiftReg;
  logic [W-1:0] aluOut;    // Combinational result
  logic [W-1:0] latchReg;  // Held result in latch mode
  logic         isShift;

  assign sum   = in1 + in2;
  // One 33-bit subtract feeds SUB and both compares
  assign minus = {1'b1, ~in2} + {1'b0, in1} + {{W{1'b0}}, 1'b1};
  assign ltu   = minus[W];
  // Signs differ, so in1 is smaller exactly when it is negative
  assign lt    = (in1[W-1] ^ in2[W-1]) ? in1[W-1] : minus[W];

  assign isShift = (func == nrvAluPkg::sll) || (func == nrvAluPkg::srl);

  aluShifter #(
    .TWOSTAGE (TWOSTAGE)
  ) i_shifter (
    .clk      (clk),
    .rstN     (rstN),
    .wr       (wr),
    .func     (func),
    .arith    (funcQual),
    .in1      (in1),
    .shamtIn  (in2[`SHAMT_WIDTH-1:0]),
    .shiftReg (shiftReg),
    .busy     (busy)
  );

  always_comb begin
    case (func)
      nrvAluPkg::add:   aluOut = funcQual ? minus[W-1:0] : sum;  // ADD/SUB
      nrvAluPkg::slt:   aluOut = {{(W-1){1'b0}}, lt};
      nrvAluPkg::sltu:  aluOut = {{(W-1){1'b0}}, ltu};
      nrvAluPkg::xorOp: aluOut = in1 ^ in2;
      nrvAluPkg::orOp:  aluOut = in1 | in2;
      nrvAluPkg::andOp: aluOut = in1 & in2;
      default:          aluOut = shiftReg;                       // SLL, SRL/SRA
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      latchReg <= '0;
    end else if (wr && !isShift) begin
      latchReg <= aluOut;  // Capture on start, hold until next op
    end
  end

  // Shifts always come from the shifter register
  assign result = (LATCH && !isShift) ? latchReg : aluOut;

endmodule

// File: verilog/aluWbSlave.sv
`include "nrvAlu_defines.svh"

module aluWbSlave (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     cyc,
  input  logic                     stb,
  input  logic                     we,
  input  logic [`WB_ADR_WIDTH-1:0] adr,       // Word address
  input  logic [`ALU_WIDTH-1:0]    datW,
  output logic [`ALU_WIDTH-1:0]    datR,
  output logic                     ack,
  input  logic [`ALU_WIDTH-1:0]    result,
  input  logic [`ALU_WIDTH-1:0]    sum,
  input  logic                     busy,
  output logic [`ALU_WIDTH-1:0]    in1,
  output logic [`ALU_WIDTH-1:0]    in2,
  output nrvAluPkg::aluFunc        func,
  output logic                     funcQual,
  output logic                     wr         // Start pulse, same cycle as ack
);

  localparam int W = `ALU_WIDTH;

  nrvAluPkg::regIndex adrIdx;
  logic               req;         // Access pending
  logic               stall;       // Held off by a running shift
  logic               ackNext;     // Access completes at this edge
  logic [W-1:0]       opWord;      // Readback of the operation word
  logic [W-1:0]       statusWord;
  logic [W-1:0]       readMux;

  assign adrIdx = nrvAluPkg::regIndex'(adr);
  assign req    = cyc && stb && !ack;  // Never ack twice running

  // Result reads and operand or op writes wait for the shifter
  assign stall = busy && (we ? (adrIdx == nrvAluPkg::in1Reg ||
                                adrIdx == nrvAluPkg::in2Reg ||
                                adrIdx == nrvAluPkg::opReg)
                             : (adrIdx == nrvAluPkg::resultReg));

  assign ackNext = req && !stall;

  always_comb begin
    opWord = '0;
    opWord[`OP_FUNC_MSB:`OP_FUNC_LSB] = func;
    opWord[`OP_QUAL_BIT]              = funcQual;
    statusWord = '0;
    statusWord[`STATUS_BUSY_BIT] = busy;
  end

  always_comb begin
    case (adrIdx)
      nrvAluPkg::in1Reg:    readMux = in1;
      nrvAluPkg::in2Reg:    readMux = in2;
      nrvAluPkg::opReg:     readMux = opWord;
      nrvAluPkg::resultReg: readMux = result;
      nrvAluPkg::sumReg:    readMux = sum;
      nrvAluPkg::statusReg: readMux = statusWord;
      default:              readMux = '0;  // Unmapped words
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ack      <= 1'b0;
      wr       <= 1'b0;
      datR     <= '0;
      in1      <= '0;
      in2      <= '0;
      func     <= nrvAluPkg::add;
      funcQual <= 1'b0;
    end else begin
      ack <= ackNext;                                     // One wait state minimum
      wr  <= ackNext && we && (adrIdx == nrvAluPkg::opReg);
      if (ackNext && !we) begin
        datR <= readMux;
      end
      if (ackNext && we) begin
        case (adrIdx)
          nrvAluPkg::in1Reg: in1 <= datW;
          nrvAluPkg::in2Reg: in2 <= datW;
          nrvAluPkg::opReg: begin
            func     <= nrvAluPkg::aluFunc'(datW[`OP_FUNC_MSB:`OP_FUNC_LSB]);
            funcQual <= datW[`OP_QUAL_BIT];
          end
          default: ;                                      // Read-only words
        endcase
      end
    end
  end

endmodule

// File: verilog/aluUnit.sv
`include "nrvAlu_defines.svh"

module aluUnit #(
  parameter bit TWOSTAGE = `ALU_TWOSTAGE,
  parameter bit LATCH    = `ALU_LATCH
) (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     cyc,
  input  logic                     stb,
  input  logic                     we,
  input  logic [`WB_ADR_WIDTH-1:0] adr,
  input  logic [`ALU_WIDTH-1:0]    datW,
  output logic [`ALU_WIDTH-1:0]    datR,
  output logic                     ack
);

  logic [`ALU_WIDTH-1:0] in1;       // Operands from the slave
  logic [`ALU_WIDTH-1:0] in2;
  nrvAluPkg::aluFunc     func;
  logic                  funcQual;
  logic                  wr;        // Operation start
  logic [`ALU_WIDTH-1:0] result;    // Back from the core
  logic [`ALU_WIDTH-1:0] sum;
  logic                  busy;

  aluWbSlave i_slave (
    .clk(clk), .rstN(rstN),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW), .datR(datR), .ack(ack),
    .result(result), .sum(sum), .busy(busy),
    .in1(in1), .in2(in2), .func(func), .funcQual(funcQual), .wr(wr)
  );

  aluCore #(
    .TWOSTAGE (TWOSTAGE),
    .LATCH    (LATCH)
  ) i_core (
    .clk(clk), .rstN(rstN),
    .in1(in1), .in2(in2), .func(func), .funcQual(funcQual), .wr(wr),
    .result(result), .sum(sum), .busy(busy)
  );

endmodule

// File: bench/aluUnit_properties.sv
module aluUnit_properties (
  input logic clk,
  input logic rstN,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic wr,    // Operation start inside the DUT
  input logic busy   // Shifter running
);

  timeunit 1ns;
  timeprecision 100ps;

  ackSingle: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
    else $error("ack stayed high for two cycles");

  ackInCycle: assert property (@(posedge clk) disable iff (!rstN) ack |-> (cyc && stb))
    else $error("ack raised outside an active cycle");

  startWhenIdle: assert property (@(posedge clk) disable iff (!rstN) wr |-> !busy)
    else $error("operation started while the shifter was busy");

endmodule

// File: bench/aluUnit_tb.sv
`include "nrvAlu_defines.svh"

module aluUnit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES     = 16;
  localparam int CYCLES_PER_ENTRY = 60;  // Seven transfers plus longest shift

  typedef struct packed {
    nrvAluPkg::aluFunc     func;
    logic                  qual;      // SUB or SRA
    logic [`ALU_WIDTH-1:0] a;
    logic [`ALU_WIDTH-1:0] b;
    logic [`ALU_WIDTH-1:0] expected;
  } entryT;

  logic                     clk;
  logic                     rstN;
  logic                     cyc;
  logic                     stb;
  logic                     we;
  logic [`WB_ADR_WIDTH-1:0] adr;
  logic [`ALU_WIDTH-1:0]    datW;
  logic [`ALU_WIDTH-1:0]    datR;
  logic                     ack;
  logic [31:0]              lfsr = 32'd69846;  // Seed
  entryT                    vectors[$];
  int                       tableLen = 0;
  bit                       verdictShown = 1'b0;

  aluUnit #(.TWOSTAGE(1'b1), .LATCH(1'b1)) i_dut (
    .clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we),
    .adr(adr), .datW(datW), .datR(datR), .ack(ack)
  );

  bind aluUnit aluUnit_properties i_props (
    .clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .ack(ack), .wr(wr), .busy(busy)
  );

  always #5 clk = ~clk;  // 10 ns period

  // x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [31:0] lfsrBits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // RV32I register-register semantics
  function automatic logic [`ALU_WIDTH-1:0] rv32Reference(input nrvAluPkg::aluFunc f,
      input logic q, input logic [`ALU_WIDTH-1:0] a, input logic [`ALU_WIDTH-1:0] b);
    logic [4:0]                   sh;
    logic signed [`ALU_WIDTH-1:0] sa;
    sh = b[4:0];  // Only low five bits count
    sa = a;
    case (f)
      nrvAluPkg::add:   return q ? a - b : a + b;
      nrvAluPkg::sll:   return a << sh;
      nrvAluPkg::slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      nrvAluPkg::sltu:  return (a < b) ? 32'd1 : 32'd0;
      nrvAluPkg::xorOp: return a ^ b;
      nrvAluPkg::srl: begin
        if (q) begin
          return sa >>> sh;  // SRA keeps the sign
        end
        return a >> sh;
      end
      nrvAluPkg::orOp:  return a | b;
      default:          return a & b;
    endcase
  endfunction

  task automatic addEntry(input nrvAluPkg::aluFunc f, input logic q,
                          input logic [`ALU_WIDTH-1:0] a, input logic [`ALU_WIDTH-1:0] b);
    entryT e;
    e.func     = f;
    e.qual     = q;
    e.a        = a;
    e.b        = b;
    e.expected = rv32Reference(f, q, a, b);
    vectors.push_back(e);
  endtask

  task automatic buildTable();
    logic [31:0] r;
    logic [31:0] b;
    addEntry(nrvAluPkg::add,   1'b0, 32'h7FFF_FFFF, 32'h0000_0001);  // Signed overflow
    addEntry(nrvAluPkg::add,   1'b1, 32'h8000_0000, 32'h0000_0001);  // SUB wraps positive
    addEntry(nrvAluPkg::add,   1'b1, 32'h1234_5678, 32'h1234_5678);  // Equal
    addEntry(nrvAluPkg::slt,   1'b0, 32'hFFFF_FFFF, 32'h0000_0001);  // Opposite signs
    addEntry(nrvAluPkg::slt,   1'b0, 32'h0000_0001, 32'hFFFF_FFFF);
    addEntry(nrvAluPkg::slt,   1'b0, 32'h8000_0000, 32'h7FFF_FFFF);
    addEntry(nrvAluPkg::slt,   1'b0, 32'hDEAD_BEEF, 32'hDEAD_BEEF);
    addEntry(nrvAluPkg::sltu,  1'b0, 32'hFFFF_FFFF, 32'h0000_0001);
    addEntry(nrvAluPkg::sltu,  1'b0, 32'h0000_0001, 32'hFFFF_FFFF);
    addEntry(nrvAluPkg::sltu,  1'b0, 32'h0000_0000, 32'h0000_0000);
    addEntry(nrvAluPkg::xorOp, 1'b0, 32'hF0F0_A5A5, 32'hFF00_5A5A);
    addEntry(nrvAluPkg::orOp,  1'b0, 32'hF0F0_A5A5, 32'h0F00_5A00);
    addEntry(nrvAluPkg::andOp, 1'b0, 32'hF0F0_A5A5, 32'hFF00_5A5F);
    // Every shift amount on all three shifts
    for (int sh = 0; sh < 32; sh++) begin
      b      = lfsrBits(32);
      b[4:0] = sh[4:0];
      addEntry(nrvAluPkg::sll, 1'b0, lfsrBits(32) | 32'h8000_0001, b);
      addEntry(nrvAluPkg::srl, 1'b0, lfsrBits(32) | 32'h8000_0000, b);
      addEntry(nrvAluPkg::srl, 1'b1, lfsrBits(32) | 32'h8000_0000, b);  // Sign fill
    end
    for (int i = 0; i < 40; i++) begin
      r = lfsrBits(4);
      addEntry(nrvAluPkg::aluFunc'(r[2:0]), r[3], lfsrBits(32), lfsrBits(32));
    end
  endtask

  task automatic waitAck();
    do @(negedge clk); while (ack !== 1'b1);  // Sample away from the active edge
  endtask

  // cyc and stb stay up between back-to-back transfers
  task automatic wbWrite(input nrvAluPkg::regIndex idx, input logic [`ALU_WIDTH-1:0] data);
    @(posedge clk);
    cyc  <= 1'b1;
    stb  <= 1'b1;
    we   <= 1'b1;
    adr  <= idx;
    datW <= data;
    waitAck();
  endtask

  task automatic wbRead(input nrvAluPkg::regIndex idx, output logic [`ALU_WIDTH-1:0] data);
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= idx;
    waitAck();
    data = datR;  // Registered with ack
  endtask

  task automatic busIdle();
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic failRun(input string why);
    $display("%s", why);
    verdictShown = 1'b1;
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping on first error");
  endtask

  task automatic checkWord(input string name, input logic [`ALU_WIDTH-1:0] got,
                           input logic [`ALU_WIDTH-1:0] exp);
    if (got !== exp) begin
      failRun($sformatf("Fail at %0d ns: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic checkBusy(input logic got, input logic exp);
    if (got !== exp) begin
      failRun($sformatf("Fail at %0d ns: busy got %b expected %b", $time, got, exp));
    end
  endtask

  task automatic applyEntry(input entryT e, input bit readFirst);
    logic [`ALU_WIDTH-1:0] opWord;
    logic [`ALU_WIDTH-1:0] rd;
    logic                  shiftStarts;
    opWord = '0;
    opWord[`OP_FUNC_MSB:`OP_FUNC_LSB] = e.func;
    opWord[`OP_QUAL_BIT]              = e.qual;
    shiftStarts = (e.func == nrvAluPkg::sll || e.func == nrvAluPkg::srl) && (e.b[4:0] != 5'd0);
    wbWrite(nrvAluPkg::in1Reg, e.a);
    wbWrite(nrvAluPkg::in2Reg, e.b);
    wbWrite(nrvAluPkg::opReg, opWord);
    wbRead(nrvAluPkg::statusReg, rd);               // Right after the start
    checkBusy(rd[`STATUS_BUSY_BIT], shiftStarts);
    if (readFirst) begin
      wbRead(nrvAluPkg::resultReg, rd);             // Held off until the shift ends
      checkWord("resultReg", rd, e.expected);
      wbWrite(nrvAluPkg::in1Reg, ~e.a);
    end else begin
      wbWrite(nrvAluPkg::in1Reg, ~e.a);             // Stalled while a shift runs
      wbRead(nrvAluPkg::resultReg, rd);
      checkWord("resultReg", rd, e.expected);
    end
    wbRead(nrvAluPkg::sumReg, rd);
    checkWord("sumReg", rd, ~e.a + e.b);            // Adder sees the new in1
  endtask

  initial begin
    wait (tableLen != 0);
    repeat (tableLen * CYCLES_PER_ENTRY + RESET_CYCLES + 40) @(posedge clk);
    failRun($sformatf("Watchdog expired at %0d ns, the bus hung waiting for ack", $time));
  end

  initial begin
    logic [`ALU_WIDTH-1:0] rd;
    clk  = 1'b0;
    rstN = 1'b0;
    cyc  = 1'b0;
    stb  = 1'b0;
    we   = 1'b0;
    adr  = '0;
    datW = '0;
    buildTable();
    tableLen = vectors.size();
    repeat (RESET_CYCLES) @(posedge clk);
    rstN <= 1'b1;
    wbRead(nrvAluPkg::statusReg, rd);
    checkWord("statusReg", rd, '0);
    wbRead(nrvAluPkg::resultReg, rd);
    checkWord("resultReg", rd, '0);
    foreach (vectors[i]) begin
      applyEntry(vectors[i], (i % 2) == 0);  // Alternate read or write during the shift
    end
    busIdle();
    repeat (2) @(posedge clk);
    verdictShown = 1'b1;
    $display("TEST RESULT: PASS");
    $finish;
  end

  // Stops raised by the bound assertions end here
  final begin
    if (!verdictShown) begin
      $display("TEST RESULT: FAIL");
    end
  end

endmodule

// File: vlog.f
+incdir+common
common/nrvAluPkg.sv
alu/aluShifter.sv
alu/aluCore.sv
verilog/aluWbSlave.sv
verilog/aluUnit.sv
bench/aluUnit_properties.sv
bench/aluUnit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module aluUnit_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ValuUnit_tb > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
  echo "Simulator exited with status $simStatus"
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
